// ==== filelist.f ====
+incdir+include
src/bus_arb_pkg.sv
src/credit_bank.sv
src/starve_guard.sv
src/addr_router.sv
src/bid_arbiter.sv
src/bus_arb_top.sv
test/tb_slave_mem.sv
test/tb_bus_arb.sv

// ==== include/bus_arb_config.svh ====
// ##########################################################
// sizes and credit constants of the bid-arbitrated bus,
// included by the package and by every module using them
// ##########################################################

`ifndef BUS_ARB_CONFIG_SVH
`define BUS_ARB_CONFIG_SVH

// ##########################################################
// bus shape

`define BA_NUM_MASTERS   4      // requesters on the shared bus
`define BA_NUM_SLAVES    4      // slaves decoded from adr[15:12]
`define BA_ADDR_W        16     // top nibble picks the slave
`define BA_DATA_W        32
`define BA_BID_W         4      // bid of zero means no request

// ##########################################################
// credit and starvation

`define BA_BAL_W         10     // wide enough for the ceiling
`define BA_BAL_INIT      750    // balance out of reset
`define BA_BAL_REFILL    750    // added once per refill period
`define BA_BAL_MAX       900    // refill never goes past this
`define BA_REFILL_PERIOD 400    // cycles between refills
`define BA_STARVE_LIMIT  60     // waiting cycles before forced grant

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the bus testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_bus_arb \
    -f filelist.f --Mdir obj_dir -o tb_bus_arb

./obj_dir/tb_bus_arb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== src/addr_router.sv ====
// ##########################################################
// combinational path from the bus owner to the slave picked
// by adr[15:12]; unmapped addresses are acked here
// ##########################################################

`include "bus_arb_config.svh"

module addr_router import bus_arb_pkg::*; (
    input  mst_req_t mst_req [`BA_NUM_MASTERS],
    input  grant_t   grant,
    output wb_rsp_t  mst_rsp [`BA_NUM_MASTERS],
    output wb_req_t  slv_req [`BA_NUM_SLAVES],
    input  wb_rsp_t  slv_rsp [`BA_NUM_SLAVES]
);

    localparam int N      = `BA_NUM_MASTERS;
    localparam int S      = `BA_NUM_SLAVES;
    localparam int SLV_IW = $clog2(`BA_NUM_SLAVES);

    mst_req_t          owner_req;
    logic [3:0]        sel;          // top address nibble
    logic              mapped;
    logic [SLV_IW-1:0] slv_idx;
    wb_rsp_t           sel_rsp;

    // ######################################################
    // owner request and slave decode

    always_comb begin
        owner_req = '0;              // idle bus drives nothing
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                owner_req = mst_req[i];
            end
        end
    end

    assign sel     = owner_req.adr[`BA_ADDR_W-1 -: 4];
    assign mapped  = (sel < 4'(S));
    assign slv_idx = sel[SLV_IW-1:0];

    // payload goes to every slave, only the addressed one sees cyc and stb
    always_comb begin
        for (int s = 0; s < S; s++) begin
            slv_req[s].cyc = owner_req.cyc & mapped & (slv_idx == SLV_IW'(s));
            slv_req[s].stb = owner_req.stb & mapped & (slv_idx == SLV_IW'(s));
            slv_req[s].we  = owner_req.we;
            slv_req[s].adr = owner_req.adr;
            slv_req[s].dat = owner_req.dat;
        end
    end

    // ######################################################
    // response back to the owner

    always_comb begin
        if (mapped) begin
            sel_rsp = slv_rsp[slv_idx];
        end else begin
            sel_rsp.dat = '0;                               // no slave there, read zero
            sel_rsp.ack = owner_req.cyc & owner_req.stb;    // same-cycle ack
        end
        for (int i = 0; i < N; i++) begin
            mst_rsp[i].dat = sel_rsp.dat;
            mst_rsp[i].ack = grant[i] & sel_rsp.ack;
        end
    end

endmodule

// ==== src/bid_arbiter.sv ====
// ##########################################################
// bus ownership register and winner selection, also owns
// the refill timer and one credit bank per master
// ##########################################################

`include "bus_arb_config.svh"

module bid_arbiter import bus_arb_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  mst_req_t                   mst_req [`BA_NUM_MASTERS],
    input  logic [`BA_NUM_MASTERS-1:0] starving,
    output grant_t                     grant
);

    localparam int N     = `BA_NUM_MASTERS;
    localparam int REF_W = $clog2(`BA_REFILL_PERIOD);

    logic [REF_W-1:0] refill_cnt;
    logic             refill;
    mst_idx_t         rr_ptr;         // last owner
    logic [N-1:0]     afford;
    logic [N-1:0]     charge;
    logic [N-1:0]     cyc_vec;
    logic [N-1:0]     starve_cand;
    logic [N-1:0]     bid_cand;
    logic [N-1:0]     tie_cand;
    bid_t             top_bid;
    grant_t           winner;
    mst_idx_t         winner_idx;
    mst_idx_t         scan_idx;
    logic             owner_cyc;

    // ######################################################
    // shared refill timer, pulses on the last cycle of each period

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refill_cnt <= '0;
        end else if (refill) begin
            refill_cnt <= '0;
        end else begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    assign refill = (refill_cnt == REF_W'(`BA_REFILL_PERIOD - 1));

    // ######################################################
    // candidates and the top affordable bid

    always_comb begin
        top_bid = '0;
        for (int i = 0; i < N; i++) begin
            cyc_vec[i]     = mst_req[i].cyc;
            starve_cand[i] = mst_req[i].cyc & starving[i];
            bid_cand[i]    = mst_req[i].cyc & (mst_req[i].bid != '0) & afford[i];
            if (bid_cand[i] && (mst_req[i].bid > top_bid)) begin
                top_bid = mst_req[i].bid;
            end
        end
        for (int i = 0; i < N; i++) begin
            tie_cand[i] = bid_cand[i] & (mst_req[i].bid == top_bid);
        end
    end

    // starving masters first, lowest index; otherwise first tie after rr_ptr
    always_comb begin
        winner     = '0;
        winner_idx = rr_ptr;
        scan_idx   = rr_ptr;
        if (|starve_cand) begin
            for (int i = N - 1; i >= 0; i--) begin
                if (starve_cand[i]) begin
                    winner_idx = mst_idx_t'(i);    // lower index overwrites
                end
            end
            winner = grant_t'(1) << winner_idx;
        end else if (|tie_cand) begin
            for (int k = N; k >= 1; k--) begin     // nearest after rr_ptr is taken last
                scan_idx = mst_idx_t'((int'(rr_ptr) + k) % N);
                if (tie_cand[scan_idx]) begin
                    winner_idx = scan_idx;
                end
            end
            winner = grant_t'(1) << winner_idx;
        end
    end

    // ######################################################
    // ownership, held while the owner keeps cyc

    assign owner_cyc = |(grant & cyc_vec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant  <= '0;
            rr_ptr <= mst_idx_t'(N - 1);
        end else if (grant != '0) begin
            if (!owner_cyc) begin
                grant <= '0;                       // one idle cycle after each tenure
            end
        end else if (winner != '0) begin
            grant  <= winner;
            rr_ptr <= winner_idx;
        end
    end

    assign charge = (grant == '0) ? winner : '0;   // bid is paid on the granting edge

    for (genvar i = 0; i < N; i++) begin : g_bank
        credit_bank u_bank (
            .clk    (clk),
            .rst    (rst),
            .bid    (mst_req[i].bid),
            .charge (charge[i]),
            .refill (refill),
            .afford (afford[i])
        );
    end

endmodule

// ==== src/bus_arb_pkg.sv ====
// ##########################################################
// request, response and index types shared by the RTL
// and the testbench, sized from the config header
// ##########################################################

`include "bus_arb_config.svh"

package bus_arb_pkg;

    // ######################################################
    // scalar types

    typedef logic [`BA_NUM_MASTERS-1:0]         grant_t;    // one-hot owner, zero when idle
    typedef logic [`BA_BID_W-1:0]               bid_t;
    typedef logic [`BA_BAL_W-1:0]               balance_t;
    typedef logic [$clog2(`BA_NUM_MASTERS)-1:0] mst_idx_t;

    // ######################################################
    // bus records

    // what a master drives, Wishbone classic plus its bid
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`BA_ADDR_W-1:0] adr;
        logic [`BA_DATA_W-1:0] dat;
        bid_t                  bid;
    } mst_req_t;

    // what a slave sees from the current owner
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`BA_ADDR_W-1:0] adr;
        logic [`BA_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [`BA_DATA_W-1:0] dat;    // read data, valid with ack
        logic                  ack;    // single-cycle pulse
    } wb_rsp_t;

endpackage

// ==== src/bus_arb_top.sv ====
// ##########################################################
// shared bus top level, four masters to four slaves with
// bid arbitration, credit, starvation guard and routing
// ##########################################################

`include "bus_arb_config.svh"

module bus_arb_top import bus_arb_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mst_req_t mst_req [`BA_NUM_MASTERS],
    output wb_rsp_t  mst_rsp [`BA_NUM_MASTERS],
    output wb_req_t  slv_req [`BA_NUM_SLAVES],
    input  wb_rsp_t  slv_rsp [`BA_NUM_SLAVES],
    output grant_t   grant
);

    logic [`BA_NUM_MASTERS-1:0] starving;    // per master, waited too long

    // ######################################################
    // arbitration with its credit banks

    bid_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .mst_req  (mst_req),
        .starving (starving),
        .grant    (grant)
    );

    // ######################################################
    // wait counters, fed back into the winner rule

    starve_guard u_starve (
        .clk      (clk),
        .rst      (rst),
        .mst_req  (mst_req),
        .grant    (grant),
        .starving (starving)
    );

    // ######################################################
    // owner to slave data path

    addr_router u_router (
        .mst_req (mst_req),
        .grant   (grant),
        .mst_rsp (mst_rsp),
        .slv_req (slv_req),
        .slv_rsp (slv_rsp)
    );

endmodule

// ==== src/credit_bank.sv ====
// ##########################################################
// credit balance of one master, capped refill then
// floored charge, and a flag for an affordable bid
// ##########################################################

`include "bus_arb_config.svh"

module credit_bank import bus_arb_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  bid_t bid,
    input  logic charge,
    input  logic refill,
    output logic afford
);

    localparam int W     = `BA_BAL_W;
    localparam int SUM_W = W + 1;

    balance_t         balance;
    balance_t         topped;     // balance after this cycle's refill
    balance_t         cost;
    logic [SUM_W-1:0] sum;

    assign cost = balance_t'(bid);
    assign sum  = {1'b0, balance} + SUM_W'(`BA_BAL_REFILL);

    always_comb begin
        topped = balance;
        if (refill) begin
            if (sum > SUM_W'(`BA_BAL_MAX)) begin
                topped = balance_t'(`BA_BAL_MAX);
            end else begin
                topped = sum[W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            balance <= balance_t'(`BA_BAL_INIT);
        end else if (charge) begin
            balance <= (topped >= cost) ? topped - cost : '0;    // floors at zero
        end else begin
            balance <= topped;
        end
    end

    assign afford = (balance >= cost);

endmodule

// ==== src/starve_guard.sv ====
// ##########################################################
// per-master wait counters, a master waiting long enough
// is flagged so the arbiter grants it next
// ##########################################################

`include "bus_arb_config.svh"

module starve_guard import bus_arb_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  mst_req_t                   mst_req [`BA_NUM_MASTERS],
    input  grant_t                     grant,
    output logic [`BA_NUM_MASTERS-1:0] starving
);

    localparam int N     = `BA_NUM_MASTERS;
    localparam int CNT_W = $clog2(`BA_STARVE_LIMIT + 1);

    logic [CNT_W-1:0] wait_cnt [N];

    // counts only while requesting and not the owner
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                wait_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (!mst_req[i].cyc || grant[i]) begin
                    wait_cnt[i] <= '0;
                end else if (wait_cnt[i] != CNT_W'(`BA_STARVE_LIMIT)) begin
                    wait_cnt[i] <= wait_cnt[i] + 1'b1;    // sticks at the limit
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            starving[i] = (wait_cnt[i] >= CNT_W'(`BA_STARVE_LIMIT));
        end
    end

endmodule

// ==== test/tb_bus_arb.sv ====
// ##########################################################
// testbench for the bid-arbitrated bus with random masters
// checked every cycle against a model of grants, credit and routing
// ##########################################################

`include "bus_arb_config.svh"

module tb_bus_arb import bus_arb_pkg::*; ();

    localparam int N          = `BA_NUM_MASTERS;
    localparam int S          = `BA_NUM_SLAVES;
    localparam int LEN_RANDOM = 3000;
    localparam int LEN_CREDIT = 1500;
    localparam int LEN_STARVE = 400;
    localparam int LEN_ROUTE  = 2000;
    localparam int MAX_CYCLES = 35 + LEN_RANDOM + LEN_CREDIT + LEN_STARVE + LEN_ROUTE + 1000;

    typedef enum int {M_IDLE, M_SINGLE, M_RANDOM, M_CREDIT, M_STARVE} mode_e;
    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_XFER} mst_state_e;

    logic       clk;
    logic       rst;
    mst_req_t   mst_req [N];
    wb_rsp_t    mst_rsp [N];
    wb_req_t    slv_req [S];
    wb_rsp_t    slv_rsp [S];
    grant_t     grant;
    logic [15:0] lfsr;
    mode_e      mode;
    mst_state_e st [N];
    int         gap [N];
    grant_t     m_grant;          // model state from here on
    int         m_rr;
    int         m_refcnt;
    int         m_bal [N];
    int         m_wait [N];
    logic [31:0] shadow [S][16];
    int         errors;
    int         checks;
    int         base;
    int         cycles;
    int         min_bal;
    int         starve_wins;
    int         reads;
    int         unmapped;

    bus_arb_top dut (
        .clk     (clk),
        .rst     (rst),
        .mst_req (mst_req),
        .mst_rsp (mst_rsp),
        .slv_req (slv_req),
        .slv_rsp (slv_rsp),
        .grant   (grant)
    );

    for (genvar s = 0; s < S; s++) begin : g_slv
        tb_slave_mem #(.ID(s)) u_mem (.clk(clk), .rst(rst), .req(slv_req[s]), .rsp(slv_rsp[s]));
    end

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ######################################################
    // random source and data patterns

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);    // galois with taps 16 14 13 11
    endfunction

    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(int s, int a);
        return {8'ha5, 4'(s), 4'(a), 8'(a * 29 + s), 8'(~a)};
    endfunction

    function automatic logic master_on(int i);
        case (mode)
            M_IDLE:   return 1'b0;
            M_SINGLE: return i == 0;
            M_CREDIT: return i < 3;           // master 3 sits this one out
            default:  return 1'b1;
        endcase
    endfunction

    function automatic bid_t pick_bid(int i);
        case (mode)
            M_CREDIT: return (i == 0) ? bid_t'(15) : bid_t'(4);
            M_STARVE: return (i == 0) ? bid_t'(1) : bid_t'(15);
            default:  return bid_t'(rand_bits(4));
        endcase
    endfunction

    function automatic int pick_gap(int i);
        case (mode)
            M_CREDIT: return (i == 0) ? 0 : int'(rand_bits(2));
            M_STARVE: return 0;
            default:  return int'(rand_bits(3));
        endcase
    endfunction

    // nibbles 12 and 13 land outside the slave map
    function automatic logic [15:0] pick_adr();
        int u;
        u = int'(rand_bits(3));
        return {4'((u >= 6) ? u + 6 : u % 4), 8'h00, 4'(rand_bits(4))};
    endfunction

    // ######################################################
    // compare tasks

    task automatic report_miss(string msg);
        errors++;
        $display("error @%0t: %s", $time, msg);
    endtask

    task automatic check_grant(grant_t exp);
        checks++;
        if (grant !== exp) begin
            report_miss($sformatf("grant %b, expected %b", grant, exp));
        end
    endtask

    task automatic check_rsp(int m, wb_rsp_t exp, logic with_dat);
        checks++;
        if (mst_rsp[m].ack !== exp.ack || (with_dat && mst_rsp[m].dat !== exp.dat)) begin
            report_miss($sformatf("master %0d response %h, expected %h", m, mst_rsp[m], exp));
        end
    endtask

    task automatic check_slv(int s, wb_req_t exp);
        checks++;
        if (slv_req[s].cyc !== exp.cyc || slv_req[s].stb !== exp.stb
                || (exp.cyc && slv_req[s] !== exp)) begin
            report_miss($sformatf("slave %0d request %h, expected %h", s, slv_req[s], exp));
        end
    endtask

    // ######################################################
    // reference model stepped once per clock edge

    function automatic logic can_bid(int i);
        return mst_req[i].cyc && mst_req[i].bid != 0 && m_bal[i] >= int'(mst_req[i].bid);
    endfunction

    task automatic model_step();
        logic         refill;
        logic         via_starve;
        logic [N-1:0] cyc_vec;
        grant_t       win;
        int           win_idx;
        int           top;
        int           idx;
        int           nb;
        refill     = (m_refcnt == `BA_REFILL_PERIOD - 1);
        win        = '0;
        win_idx    = 0;
        via_starve = 1'b0;
        top        = 0;
        for (int i = 0; i < N; i++) begin
            cyc_vec[i] = mst_req[i].cyc;
            if (mst_req[i].cyc && m_wait[i] >= `BA_STARVE_LIMIT && win == '0) begin
                win        = grant_t'(1 << i);    // lowest starving index
                win_idx    = i;
                via_starve = 1'b1;
            end
            if (can_bid(i) && int'(mst_req[i].bid) > top) begin
                top = mst_req[i].bid;
            end
        end
        for (int k = 1; k <= N && win == '0; k++) begin
            idx = (m_rr + k) % N;                 // first tie after the last owner
            if (can_bid(idx) && int'(mst_req[idx].bid) == top) begin
                win     = grant_t'(1 << idx);
                win_idx = idx;
            end
        end
        for (int i = 0; i < N; i++) begin
            nb = m_bal[i];
            if (refill) begin
                nb = (nb + `BA_BAL_REFILL > `BA_BAL_MAX) ? `BA_BAL_MAX : nb + `BA_BAL_REFILL;
            end
            if (m_grant == '0 && win[i]) begin
                nb = (nb > int'(mst_req[i].bid)) ? nb - int'(mst_req[i].bid) : 0;
            end
            m_bal[i] = nb;
            if (!mst_req[i].cyc || m_grant[i]) begin
                m_wait[i] = 0;
            end else if (m_wait[i] < `BA_STARVE_LIMIT) begin
                m_wait[i]++;
            end
        end
        m_refcnt = refill ? 0 : m_refcnt + 1;
        min_bal  = (m_bal[0] < min_bal) ? m_bal[0] : min_bal;
        if (m_grant != '0) begin
            if ((m_grant & cyc_vec) == '0) begin
                m_grant = '0;
            end
        end else if (win != '0) begin
            m_grant = win;
            m_rr    = win_idx;
            if (via_starve && win_idx == 0) begin
                starve_wins++;
            end
        end
    endtask

    // ######################################################
    // masters driven on the falling edge

    task automatic finish_xfer(int i);
        wb_rsp_t exp;
        int      nib;
        int      a;
        nib     = mst_req[i].adr[15:12];
        a       = mst_req[i].adr[3:0];
        exp.ack = 1'b1;
        exp.dat = '0;
        if (nib >= S) begin
            unmapped++;
            check_rsp(i, exp, 1'b1);
        end else if (mst_req[i].we) begin
            shadow[nib][a] = mst_req[i].dat;
        end else begin
            reads++;
            exp.dat = shadow[nib][a];
            check_rsp(i, exp, 1'b1);
        end
    endtask

    task automatic drive_masters();
        for (int i = 0; i < N; i++) begin
            case (st[i])
                ST_IDLE: begin
                    if (gap[i] > 0) begin
                        gap[i]--;
                    end else if (master_on(i)) begin
                        mst_req[i].cyc = 1'b1;
                        mst_req[i].bid = pick_bid(i);
                        st[i]          = ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (grant[i]) begin
                        mst_req[i].stb = 1'b1;
                        mst_req[i].we  = rand_bits(1) != 0;
                        mst_req[i].adr = pick_adr();
                        mst_req[i].dat = rand_bits(32);
                        st[i]          = ST_XFER;
                    end
                end
                default: begin
                    if (mst_rsp[i].ack) begin
                        finish_xfer(i);
                        mst_req[i] = '0;
                        gap[i]     = pick_gap(i);
                        st[i]      = ST_IDLE;
                    end
                end
            endcase
        end
    endtask

    task automatic cycle_step();
        wb_req_t exp;
        wb_rsp_t rsp_exp;
        int      o;
        @(negedge clk);
        model_step();
        check_grant(m_grant);
        o = -1;
        for (int i = 0; i < N; i++) begin
            o = m_grant[i] ? i : o;
        end
        for (int s = 0; s < S; s++) begin
            exp = '0;
            if (o >= 0 && mst_req[o].adr[15:12] == 4'(s)) begin
                exp = {mst_req[o].cyc, mst_req[o].stb, mst_req[o].we,
                       mst_req[o].adr, mst_req[o].dat};
            end
            check_slv(s, exp);
        end
        // an owner that raised stb sees its ack by the next falling edge
        for (int i = 0; i < N; i++) begin
            rsp_exp     = '0;
            rsp_exp.ack = m_grant[i] && st[i] == ST_XFER;
            check_rsp(i, rsp_exp, 1'b0);
        end
        drive_masters();
    endtask

    function automatic logic all_idle();
        for (int i = 0; i < N; i++) begin
            if (st[i] != ST_IDLE) begin
                return 1'b0;
            end
        end
        return m_grant == '0;
    endfunction

    task automatic run_phase(mode_e m, int len);
        mode = m;
        repeat (len) cycle_step();
        mode = M_IDLE;
        while (!all_idle()) begin
            cycle_step();                         // let open tenures finish
        end
    endtask

    task automatic report_test(int num, string name);
        $display("test %0d %s finished, %0d errors", num, name, errors - base);
        base = errors;
    endtask

    // ######################################################
    // test sequence

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        lfsr        = 16'd9;
        mode        = M_IDLE;
        errors      = 0;
        checks      = 0;
        base        = 0;
        cycles      = 0;
        min_bal     = `BA_BAL_MAX;
        starve_wins = 0;
        reads       = 0;
        unmapped    = 0;
        m_grant     = '0;
        m_rr        = N - 1;
        m_refcnt    = 0;
        for (int i = 0; i < N; i++) begin
            mst_req[i] = '0;
            st[i]      = ST_IDLE;
            gap[i]     = 0;
            m_bal[i]   = `BA_BAL_INIT;
            m_wait[i]  = 0;
        end
        for (int s = 0; s < S; s++) begin
            for (int a = 0; a < 16; a++) begin
                shadow[s][a] = fill_word(s, a);
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        run_phase(M_IDLE, 5);
        run_phase(M_SINGLE, 20);
        report_test(1, "reset and first grant");
        run_phase(M_RANDOM, LEN_RANDOM);
        report_test(2, "random grants");
        min_bal = `BA_BAL_MAX;
        run_phase(M_CREDIT, LEN_CREDIT);
        if (min_bal >= 15) begin
            errors++;
            $display("credit test: master 0 never ran short of credit");
        end
        report_test(3, "credit");
        starve_wins = 0;
        run_phase(M_STARVE, LEN_STARVE);
        if (starve_wins == 0) begin
            errors++;
            $display("starvation test: the low bidder was never granted by the override");
        end
        report_test(4, "starvation");
        reads    = 0;
        unmapped = 0;
        run_phase(M_RANDOM, LEN_ROUTE);
        if (reads == 0 || unmapped == 0) begin
            errors++;
            $display("routing test: no reads or no unmapped accesses took place");
        end
        report_test(5, "routing");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/tb_slave_mem.sv ====
// ##########################################################
// Wishbone classic memory slave for the testbench, acks one
// cycle after strobe, 16 words filled from slave id and address
// ##########################################################

`include "bus_arb_config.svh"

module tb_slave_mem import bus_arb_pkg::*; #(
    parameter int ID = 0
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [`BA_DATA_W-1:0] mem [16];
    logic [3:0]            a;       // word select, low address bits
    logic                  take;    // new access this cycle

    assign a    = req.adr[3:0];
    assign take = req.cyc & req.stb & ~rsp.ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp <= '0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= {8'ha5, 4'(ID), 4'(i), 8'(i * 29 + ID), 8'(~i)};
            end
        end else begin
            rsp.ack <= take;                 // single pulse, stb drops after it
            if (take) begin
                rsp.dat <= mem[a];
                if (req.we) begin
                    mem[a] <= req.dat;
                end
            end
        end
    end

endmodule
